//--- src/chase_cfg_pkg.sv
`default_nettype none

// Step sequence of the segment chase
package chase_cfg_pkg;

    // Steps in one full chase cycle, numbered 0 to num_steps-1
    localparam int unsigned num_steps = 13;

    // Bits needed to hold the largest step index
    localparam int unsigned step_width = $clog2(num_steps);

    typedef logic [step_width-1:0] step_t;

    // Both ends of the sequence, where the counter wraps
    localparam step_t step_first = step_t'(0);
    localparam step_t step_last  = step_t'(num_steps - 1);

endpackage : chase_cfg_pkg

`default_nettype wire

//--- src/seg_pkg.sv
`default_nettype none

// Seven-segment display types and the chase pattern table
package seg_pkg;

    import chase_cfg_pkg::*;

    localparam int unsigned num_digits = 4;

    // Segment a in bit 6 down to segment g in bit 0, active high
    typedef logic [6:0] seg_t;

    // One-hot digit select, bit 0 is the rightmost digit
    typedef logic [num_digits-1:0] digit_sel_t;

    typedef struct packed {
        seg_t       seg;
        digit_sel_t digit;
    } display_t;

    localparam seg_t seg_a = 7'b1000000;
    localparam seg_t seg_b = 7'b0100000;
    localparam seg_t seg_c = 7'b0010000;
    localparam seg_t seg_d = 7'b0001000;
    localparam seg_t seg_e = 7'b0000100;
    localparam seg_t seg_f = 7'b0000010;

    // End of cycle shows the right-hand pair only
    localparam seg_t seg_idle = seg_b | seg_c;

    // Digit that is lit out of reset
    localparam digit_sel_t digit_home = digit_sel_t'(1);

    // Light runs round the outer ring, lingers on d, then climbs back to a
    function automatic seg_t step_to_seg(input step_t step);
        seg_t pattern;
        case (step)
            4'd0:                      pattern = seg_a;
            4'd1:                      pattern = seg_b;
            4'd2:                      pattern = seg_c;
            4'd3, 4'd4, 4'd5, 4'd6:    pattern = seg_d;
            4'd7:                      pattern = seg_e;
            4'd8:                      pattern = seg_f;
            4'd9, 4'd10, 4'd11:        pattern = seg_a;
            default:                   pattern = seg_idle;
        endcase
        return pattern;
    endfunction

endpackage : seg_pkg

`default_nettype wire

//--- src/tick_divider.sv
`timescale 1ns/10ps
`default_nettype none

// One-cycle clock enable every DIV cycles of clock
module tick_divider #(
    parameter int unsigned DIV = 10
) (
    input  logic clock,
    input  logic rst,
    output logic tick
);

    // Keep at least one bit so DIV of 1 still elaborates
    localparam int unsigned cnt_width = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(DIV - 1);

    logic [cnt_width-1:0] count;
    logic                 wrap;

    assign wrap = (count == cnt_last);

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Decoded straight from the count, no extra register stage
    assign tick = wrap;

    generate
        if (DIV > 1) begin : g_tick_check
            // Downstream logic counts on a single-cycle enable
            a_tick_single : assert property (
                @(posedge clock) disable iff (rst)
                tick |=> !tick
            ) else $error("tick_divider: tick high on two consecutive cycles");
        end
    endgenerate

endmodule : tick_divider

`default_nettype wire

//--- src/up_down_counter.sv
`timescale 1ns/10ps
`default_nettype none

// Step counter for the chase, wraps at both ends of the sequence
module up_down_counter
    import chase_cfg_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  logic  tick,
    input  logic  up,
    output step_t step
);

    step_t step_q;
    step_t step_inc;
    step_t step_dec;
    step_t step_next;

    // Neighbours of the current step with wrap-around
    always_comb begin
        if (step_q == step_last) begin
            step_inc = step_first;
        end else begin
            step_inc = step_q + 1'b1;
        end

        if (step_q == step_first) begin
            step_dec = step_last;
        end else begin
            step_dec = step_q - 1'b1;
        end
    end

    // Direction is sampled only on the tick cycle
    assign step_next = up ? step_inc : step_dec;

    always_ff @(posedge clock) begin
        if (rst) begin
            step_q <= step_first;
        end else if (tick) begin
            step_q <= step_next;
        end
    end

    assign step = step_q;

    a_step_range : assert property (
        @(posedge clock) disable iff (rst)
        step_q <= step_last
    ) else $error("up_down_counter: step %0d beyond last step", step_q);

endmodule : up_down_counter

`default_nettype wire

//--- src/chase_display.sv
`timescale 1ns/10ps
`default_nettype none

// Digit rotation and segment decode for the chase
module chase_display
    import chase_cfg_pkg::*;
    import seg_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     tick,
    input  logic     up,
    input  step_t    step,
    output display_t display
);

    digit_sel_t digit_q;
    digit_sel_t digit_left;
    digit_sel_t digit_right;
    seg_t       seg;

    // Rotate towards the leftmost digit and wrap back to the right
    assign digit_left  = {digit_q[num_digits-2:0], digit_q[num_digits-1]};

    // Rotate towards the rightmost digit and wrap back to the left
    assign digit_right = {digit_q[0], digit_q[num_digits-1:1]};

    always_ff @(posedge clock) begin
        if (rst) begin
            digit_q <= digit_home;
        end else if (tick) begin
            if (up) begin
                digit_q <= digit_left;
            end else begin
                digit_q <= digit_right;
            end
        end
    end

    // Segments follow the step register with no added latency
    assign seg = step_to_seg(step);

    always_comb begin
        display.seg   = seg;
        display.digit = digit_q;
    end

    a_digit_onehot : assert property (
        @(posedge clock) disable iff (rst)
        $onehot(digit_q)
    ) else $error("chase_display: digit select %b not one-hot", digit_q);

endmodule : chase_display

`default_nettype wire

//--- src/segment_chase_top.sv
`timescale 1ns/10ps
`default_nettype none

// Four-digit segment chase, one step every STEP_DIV clock cycles
module segment_chase_top
    import chase_cfg_pkg::*;
    import seg_pkg::*;
#(
    // 100 MHz board clock down to a 10 Hz step rate
    parameter int unsigned STEP_DIV = 10_000_000
) (
    input  logic     clock,
    input  logic     rst,
    input  logic     up,
    output display_t display
);

    logic  tick;
    step_t step;

    tick_divider #(
        .DIV   (STEP_DIV)
    ) u_tick (
        .clock (clock),
        .rst   (rst),
        .tick  (tick)
    );

    up_down_counter u_counter (
        .clock (clock),
        .rst   (rst),
        .tick  (tick),
        .up    (up),
        .step  (step)
    );

    chase_display u_display (
        .clock   (clock),
        .rst     (rst),
        .tick    (tick),
        .up      (up),
        .step    (step),
        .display (display)
    );

endmodule : segment_chase_top

`default_nettype wire

//--- tb/segment_chase_tb.sv
`timescale 1ns/10ps
`default_nettype none

module segment_chase_tb
    import chase_cfg_pkg::*;
    import seg_pkg::*;
();

    localparam int unsigned step_div     = 5;
    localparam int unsigned change_limit = 4 * step_div;
    localparam int unsigned clock_half   = 20;

    logic     clock;
    logic     rst;
    logic     up;
    display_t display;

    // Reference model state
    int unsigned model_step;
    digit_sel_t  model_digit;

    int pass_count;
    int fail_count;
    int steps_seen;
    int wraps_up;
    int wraps_down;
    int mark_checks;
    int mark_fails;
    bit stalled;
    bit timed_out;

    segment_chase_top #(
        .STEP_DIV (step_div)
    ) u_segment_chase_top (
        .clock   (clock),
        .rst     (rst),
        .up      (up),
        .display (display)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #clock_half clock = ~clock;
        end
    end

    // Chase pattern written out from the segment map, a in bit 6
    function automatic seg_t chase_pattern(input int unsigned step);
        seg_t pattern;
        case (step)
            0:          pattern = 7'b1000000;
            1:          pattern = 7'b0100000;
            2:          pattern = 7'b0010000;
            3, 4, 5, 6: pattern = 7'b0001000;
            7:          pattern = 7'b0000100;
            8:          pattern = 7'b0000010;
            9, 10, 11:  pattern = 7'b1000000;
            default:    pattern = 7'b0110000;
        endcase
        return pattern;
    endfunction

    function automatic display_t reset_display();
        display_t result;
        result.seg   = chase_pattern(0);
        result.digit = 4'b0001;
        return result;
    endfunction

    // Moves the model one step in the given direction
    function automatic display_t predict_display(input logic dir);
        display_t result;
        if (dir) begin
            model_step  = (model_step == num_steps - 1) ? 0 : model_step + 1;
            model_digit = {model_digit[2:0], model_digit[3]};
        end else begin
            model_step  = (model_step == 0) ? num_steps - 1 : model_step - 1;
            model_digit = {model_digit[0], model_digit[3:1]};
        end
        result.seg   = chase_pattern(model_step);
        result.digit = model_digit;
        return result;
    endfunction

    task automatic check_display(input display_t expected);
        assert (display.seg == expected.seg) begin
            pass_count = pass_count + 1;
        end else begin
            fail_count = fail_count + 1;
            $display("ERR display.seg expected %h actual %h at %0t",
                     expected.seg, display.seg, $time);
        end
        assert (display.digit == expected.digit) begin
            pass_count = pass_count + 1;
        end else begin
            fail_count = fail_count + 1;
            $display("ERR display.digit expected %h actual %h at %0t",
                     expected.digit, display.digit, $time);
        end
    endtask

    // Compare process, one iteration per display change
    initial begin : compare
        display_t prev;
        display_t expected;
        logic     up_seen;
        logic     rst_seen;
        int       idle;
        int       gap;
        bit       changed;
        bit       after_reset;
        bit       wrap_up;
        bit       wrap_down;

        prev        = '0;
        after_reset = 1'b1;
        while (!stalled) begin
            idle    = 0;
            changed = 1'b0;
            while (!changed && !stalled) begin
                @(posedge clock);
                up_seen  = up;
                rst_seen = rst;
                @(negedge clock);
                if (rst_seen) begin
                    model_step  = 0;
                    model_digit = 4'b0001;
                    check_display(reset_display());
                    idle        = 0;
                    after_reset = 1'b1;
                end else if (display != prev) begin
                    changed = 1'b1;
                end else if (idle >= change_limit) begin
                    stalled    = 1'b1;
                    fail_count = fail_count + 1;
                    $display("display did not change within %0d cycles at %0t",
                             change_limit, $time);
                end else begin
                    idle = idle + 1;
                end
                prev = display;
            end
            if (changed) begin
                gap = idle + 1;
                if (after_reset) begin
                    assert (gap >= step_div) begin
                        pass_count = pass_count + 1;
                    end else begin
                        fail_count = fail_count + 1;
                        $display("display changed only %0d cycles after reset release", gap);
                    end
                end else begin
                    assert (gap == step_div) begin
                        pass_count = pass_count + 1;
                    end else begin
                        fail_count = fail_count + 1;
                        $display("ERR display period expected %h actual %h", step_div, gap);
                    end
                end
                after_reset = 1'b0;
                wrap_up     = up_seen && model_step == num_steps - 1;
                wrap_down   = !up_seen && model_step == 0;
                expected    = predict_display(up_seen);
                check_display(expected);
                // A wrap only counts once the DUT has shown the wrapped display
                if (wrap_up && display == expected) begin
                    wraps_up = wraps_up + 1;
                end
                if (wrap_down && display == expected) begin
                    wraps_down = wraps_down + 1;
                end
                steps_seen = steps_seen + 1;
            end
        end
    end

    task automatic wait_steps(input int count);
        int target;
        int cycles;
        @(posedge clock);
        target = steps_seen + count;
        cycles = 0;
        while (steps_seen < target && !timed_out && !stalled) begin
            @(posedge clock);
            cycles = cycles + 1;
            if (cycles > (count + 1) * change_limit) begin
                timed_out  = 1'b1;
                fail_count = fail_count + 1;
                $display("waited %0d cycles for %0d display steps, not all seen",
                         cycles, count);
            end
        end
        @(negedge clock);
    endtask

    task automatic begin_test();
        mark_checks = pass_count + fail_count;
        mark_fails  = fail_count;
    endtask

    task automatic end_test(input string name);
        int checks;
        int fails;
        checks = pass_count + fail_count - mark_checks;
        fails  = fail_count - mark_fails;
        if (fails == 0) begin
            $display("%s: ok, %0d checks", name, checks);
        end else begin
            $display("%s: %0d of %0d checks failed", name, fails, checks);
        end
    endtask

    initial begin : stimulus
        int wraps_before;

        rst           = 1'b1;
        up            = 1'b1;
        model_step    = 0;
        model_digit   = 4'b0001;
        pass_count    = 0;
        fail_count    = 0;
        steps_seen    = 0;
        wraps_up      = 0;
        wraps_down    = 0;
        stalled       = 1'b0;
        timed_out     = 1'b0;
        void'($urandom(65));

        begin_test();
        repeat (8) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        check_display(reset_display());
        wait_steps(1);
        end_test("reset state");

        begin_test();
        up           = 1'b1;
        wraps_before = wraps_up;
        wait_steps(30);
        assert (wraps_up > wraps_before) begin
            pass_count = pass_count + 1;
        end else begin
            fail_count = fail_count + 1;
            $display("upward chase never wrapped from the last step to step 0");
        end
        end_test("upward chase");

        begin_test();
        up           = 1'b0;
        wraps_before = wraps_down;
        wait_steps(30);
        assert (wraps_down > wraps_before) begin
            pass_count = pass_count + 1;
        end else begin
            fail_count = fail_count + 1;
            $display("downward chase never wrapped from step 0 to the last step");
        end
        end_test("downward chase");

        begin_test();
        for (int i = 0; i < 60; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                up = ~up;
            end
            wait_steps(1);
        end
        end_test("random direction changes");

        begin_test();
        up = 1'b1;
        wait_steps(20);
        end_test("step period");

        // Reset lands part way through a step
        begin_test();
        wait_steps(7);
        repeat (2) @(negedge clock);
        rst = 1'b1;
        repeat (3) @(negedge clock);
        rst = 1'b0;
        wait_steps(15);
        end_test("reset in mid-run");

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out && !stalled) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : segment_chase_tb

`default_nettype wire

//--- list.f
src/chase_cfg_pkg.sv
src/seg_pkg.sv
src/tick_divider.sv
src/up_down_counter.sv
src/chase_display.sv
src/segment_chase_top.sv
tb/segment_chase_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the segment chase testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module segment_chase_tb -Mdir "$build_dir" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$build_dir/Vsegment_chase_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$log"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
